// ==== design/dbgbus_consts.svh ====
/*
 * debug bus constants
 * widths, command opcodes, response sub-codes and scratch memory timing
 */
`ifndef DBGBUS_CONSTS_SVH
`define DBGBUS_CONSTS_SVH

// bus data and word address widths
`define DBG_DW 32
`define DBG_AW 30

// command and response words carry two code bits over a full data word
`define DBG_CMD_W 34
`define DBG_RSP_W 34

// opcodes found in command bits 33:32
`define DBG_OP_SETADDR 2'b00
`define DBG_OP_READ    2'b01
`define DBG_OP_WRITE   2'b10
`define DBG_OP_NONE    2'b11

// sub-codes found in response bits 33:32
`define RSP_SUB_ACK     2'b00
`define RSP_SUB_DATA    2'b01
`define RSP_SUB_ADDR    2'b10
`define RSP_SUB_SPECIAL 2'b11

// payloads that go with the special sub-code
`define RSP_RESET     32'h0000_0001
`define RSP_BUS_ERROR 32'h0000_0002

// scratch memory depth in words, and cycles from acceptance to ack
`define SCRATCH_WORDS     256
`define SCRATCH_ACK_DELAY 2

`endif

// ==== design/dbgbus_pkg.sv ====
/*
 * debug bus package
 * types for command and response words and for the bus address and data
 */
`include "dbgbus_consts.svh"

package dbgbus_pkg;

	// a command word from the host
	// bits 33:32 hold the opcode and bits 31:0 the payload
	typedef logic [`DBG_CMD_W-1:0] cmd_word_t;

	// a response word back to the host
	// bits 33:32 hold the sub-code and bits 31:0 the payload
	typedef logic [`DBG_RSP_W-1:0] rsp_word_t;

	// a word address on the bus
	// the two byte bits of a set-address payload are used as flags
	typedef logic [`DBG_AW-1:0] bus_addr_t;

	// one bus data word
	typedef logic [`DBG_DW-1:0] bus_data_t;

	// the command opcode field
	// see the DBG_OP_* constants for its encoding
	typedef logic [1:0] opcode_t;

endpackage

// ==== design/dbgbus_cmd_decode.sv ====
/*
 * debug bus command decoder
 * accepts command words while idle and turns each into a single-cycle
 * set-address or bus request pulse for the bus master
 */
`timescale 1ns/1ns
`include "dbgbus_consts.svh"

module dbgbus_cmd_decode (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_cmd_stb,
	input  dbgbus_pkg::cmd_word_t i_cmd_word,
	input  logic                  i_bus_active,
	output logic                  o_cmd_busy,
	output logic                  o_set_addr,
	output dbgbus_pkg::bus_addr_t o_addr_val,
	output logic                  o_addr_rel,
	output logic                  o_addr_noinc,
	output logic                  o_bus_req,
	output logic                  o_bus_we,
	output dbgbus_pkg::bus_data_t o_wr_data
);
	import dbgbus_pkg::*;

	opcode_t op;
	logic    accept;
	logic    pending;

	// the opcode sits in the two top bits of the command
	assign op = i_cmd_word[`DBG_CMD_W-1 -: 2];

	// a pulse that has not yet reached the master still counts as busy
	assign pending = o_set_addr | o_bus_req;

	// busy also covers the whole of an open bus cycle
	assign o_cmd_busy = pending | i_bus_active;

	// commands offered while busy are simply lost
	assign accept = i_cmd_stb & ~o_cmd_busy;

	// the request pulses are control state and clear on reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_set_addr <= 1'b0;
			o_bus_req  <= 1'b0;
		end
		else
		begin
			o_set_addr <= accept && (op == `DBG_OP_SETADDR);
			// reads and writes both become a bus request, the none opcode nothing
			o_bus_req  <= accept && ((op == `DBG_OP_READ) || (op == `DBG_OP_WRITE));
		end
	end

	// payload fields only change when a command is taken
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			// set-address fields, bit 1 selects relative and bit 0 stops increment
			o_addr_val   <= i_cmd_word[`DBG_DW-1:2];
			o_addr_rel   <= i_cmd_word[1];
			o_addr_noinc <= i_cmd_word[0];
			// write data is the whole payload, ignored on reads
			o_bus_we     <= (op == `DBG_OP_WRITE);
			o_wr_data    <= i_cmd_word[`DBG_DW-1:0];
		end
	end

endmodule

// ==== design/dbgbus_wb_master.sv ====
/*
 * debug bus Wishbone master
 * runs one single-word Wishbone cycle per request, keeps the bus address
 * with optional auto-increment and flags each newly set address
 */
`timescale 1ns/1ns

module dbgbus_wb_master (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_set_addr,
	input  dbgbus_pkg::bus_addr_t i_addr_val,
	input  logic                  i_addr_rel,
	input  logic                  i_addr_noinc,
	input  logic                  i_bus_req,
	input  logic                  i_bus_we,
	input  dbgbus_pkg::bus_data_t i_wr_data,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_ack,
	input  logic                  i_wb_err,
	input  dbgbus_pkg::bus_data_t i_wb_data,
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output logic                  o_wb_we,
	output dbgbus_pkg::bus_addr_t o_wb_addr,
	output dbgbus_pkg::bus_data_t o_wb_data,
	output logic                  o_bus_active,
	output logic                  o_ack_stb,
	output logic                  o_err_stb,
	output dbgbus_pkg::bus_data_t o_rd_data,
	output logic                  o_newaddr_stb,
	output logic                  o_addr_noinc
);
	import dbgbus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t    state;
	logic      accepted;
	logic      newaddr_pend;
	bus_addr_t addr_load;

	// cyc spans request and wait, stb only the request state
	assign o_wb_cyc     = (state != ST_IDLE);
	assign o_wb_stb     = (state == ST_REQ);
	assign o_bus_active = o_wb_cyc;

	// the slave takes the request once stall is low
	assign accepted = (state == ST_REQ) && !i_wb_stall;

	// an ack is only ours once the request has gone out
	assign o_ack_stb = i_wb_ack && ((state == ST_WAIT) || accepted);
	assign o_err_stb = i_wb_err && o_wb_cyc;
	assign o_rd_data = i_wb_data;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
			ST_IDLE:
				if (i_bus_req)
					state <= ST_REQ;
			ST_REQ:
				// an error clears the bus at once
				if (i_wb_err)
					state <= ST_IDLE;
				else if (accepted)
				begin
					// an ack on the accepting cycle skips the wait
					if (i_wb_ack)
						state <= ST_IDLE;
					else
						state <= ST_WAIT;
				end
			ST_WAIT:
				if (i_wb_ack || i_wb_err)
					state <= ST_IDLE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// direction is latched as the cycle opens and held until the next one
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_we <= 1'b0;
		else if ((state == ST_IDLE) && i_bus_req)
			o_wb_we <= i_bus_we;
	end

	// write data only loads in idle, so it is stable while stalled
	always_ff @(posedge i_clk)
	begin
		if ((state == ST_IDLE) && i_bus_req)
			o_wb_data <= i_wr_data;
	end

	// relative loads add the difference to the current address
	assign addr_load = i_addr_rel ? (o_wb_addr + i_addr_val) : i_addr_val;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_wb_addr    <= '0;
			o_addr_noinc <= 1'b0;
		end
		else if (i_set_addr)
		begin
			o_wb_addr    <= addr_load;
			o_addr_noinc <= i_addr_noinc;
		end
		else if (accepted && !o_addr_noinc)
			// step to the next word once the slave holds the old address
			o_wb_addr <= o_wb_addr + 1'b1;
	end

	// the add above takes a cycle, so the report waits one more
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			newaddr_pend  <= 1'b0;
			o_newaddr_stb <= 1'b0;
		end
		else
		begin
			newaddr_pend  <= i_set_addr;
			o_newaddr_stb <= newaddr_pend;
		end
	end

endmodule

// ==== design/dbgbus_rsp_encode.sv ====
/*
 * debug bus response encoder
 * turns bus outcomes and address updates into registered response words
 */
`timescale 1ns/1ns
`include "dbgbus_consts.svh"

module dbgbus_rsp_encode (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_ack_stb,
	input  logic                  i_err_stb,
	input  logic                  i_wb_we,
	input  dbgbus_pkg::bus_data_t i_rd_data,
	input  logic                  i_newaddr_stb,
	input  dbgbus_pkg::bus_addr_t i_addr,
	input  logic                  i_addr_noinc,
	output logic                  o_rsp_stb,
	output dbgbus_pkg::rsp_word_t o_rsp_word
);
	import dbgbus_pkg::*;

	logic      reset_pend;
	rsp_word_t rsp_next;

	// the reset notice wins only on its single cycle, then errors lead
	always_comb
	begin
		if (reset_pend)
			rsp_next = {`RSP_SUB_SPECIAL, `RSP_RESET};
		else if (i_err_stb)
			rsp_next = {`RSP_SUB_SPECIAL, `RSP_BUS_ERROR};
		else if (i_ack_stb && i_wb_we)
			// a write returns a bare acknowledge
			rsp_next = {`RSP_SUB_ACK, {`DBG_DW{1'b0}}};
		else if (i_ack_stb)
			rsp_next = {`RSP_SUB_DATA, i_rd_data};
		else
			// address echo, bit 1 is always zero
			rsp_next = {`RSP_SUB_ADDR, i_addr, 1'b0, i_addr_noinc};
	end

	// one-shot flag set by reset and cleared on the first free cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			reset_pend <= 1'b1;
			o_rsp_stb  <= 1'b0;
		end
		else
		begin
			reset_pend <= 1'b0;
			o_rsp_stb  <= reset_pend | i_err_stb | i_ack_stb | i_newaddr_stb;
		end
	end

	// the word is only meaningful alongside the strobe
	always_ff @(posedge i_clk)
	begin
		o_rsp_word <= rsp_next;
	end

endmodule

// ==== design/dbgbus_wb_scratch.sv ====
/*
 * Wishbone scratch memory slave
 * stalls every second request, acknowledges after a fixed delay and
 * returns err for addresses past the end of memory
 */
`timescale 1ns/1ns
`include "dbgbus_consts.svh"

module dbgbus_wb_scratch (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  dbgbus_pkg::bus_addr_t i_wb_addr,
	input  dbgbus_pkg::bus_data_t i_wb_data,
	output logic                  o_wb_stall,
	output logic                  o_wb_ack,
	output logic                  o_wb_err,
	output dbgbus_pkg::bus_data_t o_wb_data
);
	import dbgbus_pkg::*;

	localparam int IDX_W = $clog2(`SCRATCH_WORDS);

	bus_data_t mem [0:`SCRATCH_WORDS-1];

	logic                          toggle;
	logic                          stalled;
	logic                          accept;
	logic                          in_range;
	logic [IDX_W-1:0]              idx;
	logic [`SCRATCH_ACK_DELAY-1:0] ack_pipe;
	logic [`SCRATCH_ACK_DELAY-1:0] err_pipe;

	// toggle marks every second request, which then waits one cycle
	assign o_wb_stall = i_wb_cyc && i_wb_stb && toggle && !stalled;
	assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;

	assign in_range = (i_wb_addr < bus_addr_t'(`SCRATCH_WORDS));
	assign idx      = i_wb_addr[IDX_W-1:0];

	assign o_wb_ack = ack_pipe[`SCRATCH_ACK_DELAY-1];
	assign o_wb_err = err_pipe[`SCRATCH_ACK_DELAY-1];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			toggle   <= 1'b0;
			stalled  <= 1'b0;
			ack_pipe <= '0;
			err_pipe <= '0;
		end
		else
		begin
			if (accept)
			begin
				toggle  <= ~toggle;
				stalled <= 1'b0;
			end
			else if (o_wb_stall)
				stalled <= 1'b1;
			// a dropped cyc abandons whatever is still in flight
			if (!i_wb_cyc)
			begin
				ack_pipe <= '0;
				err_pipe <= '0;
			end
			else
			begin
				ack_pipe <= {ack_pipe[`SCRATCH_ACK_DELAY-2:0], accept && in_range};
				err_pipe <= {err_pipe[`SCRATCH_ACK_DELAY-2:0], accept && !in_range};
			end
		end
	end

	// out of range writes are dropped, read data holds until the next request
	always_ff @(posedge i_clk)
	begin
		if (accept && in_range)
		begin
			if (i_wb_we)
				mem[idx] <= i_wb_data;
			o_wb_data <= mem[idx];
		end
	end

endmodule

// ==== design/dbgbus_top.sv ====
/*
 * debug bus top level
 * command decoder, Wishbone master and response encoder over a scratch memory
 */
`timescale 1ns/1ns

module dbgbus_top (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_cmd_stb,
	input  dbgbus_pkg::cmd_word_t i_cmd_word,
	output logic                  o_cmd_busy,
	output logic                  o_rsp_stb,
	output dbgbus_pkg::rsp_word_t o_rsp_word
);
	import dbgbus_pkg::*;

	// decoder to master pulses and their fields
	logic      dec_set_addr, dec_addr_rel, dec_addr_noinc;
	logic      dec_bus_req, dec_bus_we;
	bus_addr_t dec_addr_val;
	bus_data_t dec_wr_data;

	// master to encoder outcomes
	logic      m_ack_stb, m_err_stb, m_newaddr_stb, m_addr_noinc, m_bus_active;
	bus_data_t m_rd_data;

	// Wishbone between master and scratch slave
	logic      wb_cyc, wb_stb, wb_we, wb_stall, wb_ack, wb_err;
	bus_addr_t wb_addr;
	bus_data_t wb_dout, wb_din;

	dbgbus_cmd_decode dbgbus_cmd_decode_inst (
		.i_clk(i_clk), .i_reset(i_reset), .i_cmd_stb(i_cmd_stb), .i_cmd_word(i_cmd_word),
		.i_bus_active(m_bus_active), .o_cmd_busy(o_cmd_busy), .o_set_addr(dec_set_addr),
		.o_addr_val(dec_addr_val), .o_addr_rel(dec_addr_rel), .o_addr_noinc(dec_addr_noinc),
		.o_bus_req(dec_bus_req), .o_bus_we(dec_bus_we), .o_wr_data(dec_wr_data)
	);

	dbgbus_wb_master dbgbus_wb_master_inst (
		.i_clk(i_clk), .i_reset(i_reset), .i_set_addr(dec_set_addr),
		.i_addr_val(dec_addr_val), .i_addr_rel(dec_addr_rel), .i_addr_noinc(dec_addr_noinc),
		.i_bus_req(dec_bus_req), .i_bus_we(dec_bus_we), .i_wr_data(dec_wr_data),
		.i_wb_stall(wb_stall), .i_wb_ack(wb_ack), .i_wb_err(wb_err), .i_wb_data(wb_din),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we), .o_wb_addr(wb_addr),
		.o_wb_data(wb_dout), .o_bus_active(m_bus_active), .o_ack_stb(m_ack_stb),
		.o_err_stb(m_err_stb), .o_rd_data(m_rd_data), .o_newaddr_stb(m_newaddr_stb),
		.o_addr_noinc(m_addr_noinc)
	);

	// the encoder reads the live bus address and direction from the master
	dbgbus_rsp_encode dbgbus_rsp_encode_inst (
		.i_clk(i_clk), .i_reset(i_reset), .i_ack_stb(m_ack_stb), .i_err_stb(m_err_stb),
		.i_wb_we(wb_we), .i_rd_data(m_rd_data), .i_newaddr_stb(m_newaddr_stb),
		.i_addr(wb_addr), .i_addr_noinc(m_addr_noinc), .o_rsp_stb(o_rsp_stb),
		.o_rsp_word(o_rsp_word)
	);

	dbgbus_wb_scratch dbgbus_wb_scratch_inst (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb),
		.i_wb_we(wb_we), .i_wb_addr(wb_addr), .i_wb_data(wb_dout), .o_wb_stall(wb_stall),
		.o_wb_ack(wb_ack), .o_wb_err(wb_err), .o_wb_data(wb_din)
	);

endmodule

// ==== testbench/dbgbus_props.sv ====
/*
 * Wishbone master properties
 * concurrent checks on the bus master's request and cycle handling
 */
`timescale 1ns/1ns

module dbgbus_props (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_bus_req,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  dbgbus_pkg::bus_addr_t i_wb_addr,
	input  dbgbus_pkg::bus_data_t i_wb_data,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_err,
	input  logic                  i_bus_active
);

	// each request is offered once and stb drops after the slave takes it
	a_single_req: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_stb && !i_wb_stall) |=> !i_wb_stb)
		else $error("wishbone stb held after the request was accepted");

	// a stalled request must be offered again unchanged
	a_req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_stb && i_wb_stall) |=> (i_wb_stb && $stable(i_wb_addr)
			&& $stable(i_wb_we) && $stable(i_wb_data)))
		else $error("wishbone request changed while stalled");

	// the decoder sees the bus as busy from the cycle after its request
	a_req_opens_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_bus_req && !i_bus_active) |=> (i_bus_active && i_wb_stb))
		else $error("bus request did not open a cycle");

	// an error ends the cycle on the following edge
	a_err_ends_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_cyc && i_wb_err) |=> !i_wb_cyc)
		else $error("cyc still high after a bus error");

endmodule

bind dbgbus_wb_master dbgbus_props dbgbus_props_inst (
	.i_clk(i_clk), .i_reset(i_reset), .i_bus_req(i_bus_req), .i_wb_cyc(o_wb_cyc),
	.i_wb_stb(o_wb_stb), .i_wb_we(o_wb_we), .i_wb_addr(o_wb_addr), .i_wb_data(o_wb_data),
	.i_wb_stall(i_wb_stall), .i_wb_err(i_wb_err), .i_bus_active(o_bus_active)
);

// ==== testbench/dbgbus_tb.sv ====
/*
 * debug bus testbench
 * drives command words into the top level and checks each response
 * against its own model of the bus address and the scratch memory
 */
`timescale 1ns/1ns
`include "dbgbus_consts.svh"

module dbgbus_tb;
	import dbgbus_pkg::*;

	localparam int IDX_W        = $clog2(`SCRATCH_WORDS);
	localparam int WAIT_LIMIT   = 50;
	localparam int QUIET_CYCLES = 12;

	logic      i_clk;
	logic      i_reset;
	logic      i_cmd_stb;
	cmd_word_t i_cmd_word;
	logic      o_cmd_busy;
	logic      o_rsp_stb;
	rsp_word_t o_rsp_word;

	int        errors;
	int        checks;
	// what the address register and memory should hold
	bus_addr_t model_addr;
	logic      model_noinc;
	bus_data_t mem_model [0:`SCRATCH_WORDS-1];

	dbgbus_top dbgbus_top_inst (
		.i_clk(i_clk), .i_reset(i_reset), .i_cmd_stb(i_cmd_stb), .i_cmd_word(i_cmd_word),
		.o_cmd_busy(o_cmd_busy), .o_rsp_stb(o_rsp_stb), .o_rsp_word(o_rsp_word)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// ends the run at once when the DUT stops answering
	task automatic abort_run(input string why);
		errors++;
		$display("ERROR: %s", why);
		$display("errors: %0d, checks: %0d", errors, checks);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic check_rsp(input string name, input rsp_word_t got, input rsp_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// command words carry the opcode on top of the payload
	function automatic cmd_word_t setaddr_cmd(input bus_addr_t val, input logic rel,
		input logic noinc);
		return {`DBG_OP_SETADDR, val, rel, noinc};
	endfunction

	function automatic cmd_word_t write_cmd(input bus_data_t data);
		return {`DBG_OP_WRITE, data};
	endfunction

	function automatic logic in_range(input bus_addr_t a);
		return a < bus_addr_t'(`SCRATCH_WORDS);
	endfunction

	// starts 1 ns after an edge and returns 1 ns after the edge that took the command
	task automatic send_cmd(input cmd_word_t word);
		int waited;
		waited = 0;
		while (o_cmd_busy && waited < WAIT_LIMIT)
		begin
			@(posedge i_clk);
			#1;
			waited++;
		end
		if (o_cmd_busy)
			abort_run("command port stayed busy");
		i_cmd_stb  = 1'b1;
		i_cmd_word = word;
		@(posedge i_clk);
		#1;
		i_cmd_stb = 1'b0;
	endtask

	// cycles counts edges from the one that took the command to the one
	// that samples the response strobe
	task automatic wait_rsp(output rsp_word_t word, output int cycles);
		int cnt;
		cnt = 0;
		do
		begin
			@(posedge i_clk);
			#1;
			cnt++;
		end
		while (!o_rsp_stb && cnt < WAIT_LIMIT);
		if (!o_rsp_stb)
			abort_run("no response strobe arrived");
		word   = o_rsp_word;
		cycles = cnt + 1;
	endtask

	task automatic set_address(input bus_addr_t val, input logic rel, input logic noinc);
		rsp_word_t rsp;
		int        lat;
		bus_addr_t exp_addr;
		exp_addr = rel ? bus_addr_t'(model_addr + val) : val;
		send_cmd(setaddr_cmd(val, rel, noinc));
		wait_rsp(rsp, lat);
		model_addr  = exp_addr;
		model_noinc = noinc;
		if (lat != 4)
		begin
			errors++;
			$display("set-address response came after %0d cycles instead of 4", lat);
		end
		check_addr("o_rsp_word address", rsp[`DBG_DW-1:2], exp_addr);
		check_rsp("o_rsp_word", rsp, {`RSP_SUB_ADDR, exp_addr, 1'b0, noinc});
	endtask

	task automatic bus_write(input bus_data_t data);
		rsp_word_t rsp;
		int        lat;
		send_cmd(write_cmd(data));
		wait_rsp(rsp, lat);
		if (in_range(model_addr))
		begin
			mem_model[model_addr[IDX_W-1:0]] = data;
			check_rsp("o_rsp_word", rsp, {`RSP_SUB_ACK, {`DBG_DW{1'b0}}});
		end
		else
			check_rsp("o_rsp_word", rsp, {`RSP_SUB_SPECIAL, `RSP_BUS_ERROR});
		// the address steps on acceptance, errors included
		if (!model_noinc)
			model_addr = model_addr + bus_addr_t'(1);
	endtask

	task automatic bus_read();
		rsp_word_t rsp;
		int        lat;
		bus_data_t exp;
		send_cmd({`DBG_OP_READ, {`DBG_DW{1'b0}}});
		wait_rsp(rsp, lat);
		if (in_range(model_addr))
		begin
			exp = mem_model[model_addr[IDX_W-1:0]];
			check_data("o_rsp_word data", rsp[`DBG_DW-1:0], exp);
			check_rsp("o_rsp_word", rsp, {`RSP_SUB_DATA, exp});
		end
		else
			check_rsp("o_rsp_word", rsp, {`RSP_SUB_SPECIAL, `RSP_BUS_ERROR});
		if (!model_noinc)
			model_addr = model_addr + bus_addr_t'(1);
	endtask

	task automatic test_reset_notice();
		rsp_word_t rsp;
		int        lat;
		wait_rsp(rsp, lat);
		check_rsp("o_rsp_word", rsp, {`RSP_SUB_SPECIAL, `RSP_RESET});
	endtask

	task automatic test_set_address();
		set_address(30'h10, 1'b0, 1'b0);
		set_address(30'h5, 1'b1, 1'b0);
		// a difference of minus three wraps within the address width
		set_address(30'h3fff_fffd, 1'b1, 1'b0);
		set_address(30'h2a, 1'b0, 1'b1);
	endtask

	task automatic test_write_read();
		int i;
		set_address(30'h20, 1'b0, 1'b0);
		for (i = 0; i < 8; i++)
			bus_write($urandom);
		set_address(30'h20, 1'b0, 1'b0);
		for (i = 0; i < 8; i++)
			bus_read();
		// a relative step of zero echoes where the address ended up
		set_address(30'h0, 1'b1, 1'b0);
	endtask

	task automatic test_no_increment();
		int i;
		set_address(30'h40, 1'b0, 1'b1);
		for (i = 0; i < 4; i++)
			bus_write($urandom);
		set_address(30'h0, 1'b1, 1'b1);
		bus_read();
		bus_read();
	endtask

	task automatic test_bus_error();
		// the last word is in range and the step past it is not
		set_address(bus_addr_t'(`SCRATCH_WORDS - 1), 1'b0, 1'b0);
		bus_write($urandom);
		bus_write($urandom);
		bus_read();
		set_address(30'h3fff_0000, 1'b0, 1'b0);
		bus_read();
		// normal traffic must still work afterwards
		set_address(30'h5, 1'b0, 1'b0);
		bus_write($urandom);
		set_address(30'h5, 1'b0, 1'b0);
		bus_read();
		set_address(bus_addr_t'(`SCRATCH_WORDS - 1), 1'b0, 1'b0);
		bus_read();
	endtask

	task automatic test_busy_drop();
		rsp_word_t rsp;
		int        lat;
		int        quiet;
		bus_data_t exp;
		set_address(30'h20, 1'b0, 1'b0);
		exp = mem_model[IDX_W'(8'h20)];
		send_cmd({`DBG_OP_READ, {`DBG_DW{1'b0}}});
		// the read's pending pulse holds busy for this cycle
		if (!o_cmd_busy)
		begin
			errors++;
			$display("o_cmd_busy was low just after a read was taken");
		end
		i_cmd_stb  = 1'b1;
		i_cmd_word = write_cmd(~mem_model[IDX_W'(8'h21)]);
		@(posedge i_clk);
		#1;
		i_cmd_stb = 1'b0;
		wait_rsp(rsp, lat);
		check_rsp("o_rsp_word", rsp, {`RSP_SUB_DATA, exp});
		model_addr = model_addr + bus_addr_t'(1);
		quiet = 0;
		while (quiet < QUIET_CYCLES)
		begin
			@(posedge i_clk);
			#1;
			quiet++;
			if (o_rsp_stb)
			begin
				errors++;
				$display("a dropped command was answered with 0x%h", o_rsp_word);
			end
		end
		// the dropped write would have landed on the next word
		set_address(30'h21, 1'b0, 1'b0);
		bus_read();
	endtask

	initial
	begin
		i_reset     = 1'b1;
		i_cmd_stb   = 1'b0;
		i_cmd_word  = '0;
		errors      = 0;
		checks      = 0;
		model_addr  = '0;
		model_noinc = 1'b0;
		void'($urandom(32'he6a1));
		repeat (5) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		test_reset_notice();
		test_set_address();
		test_write_read();
		test_no_increment();
		test_bus_error();
		test_busy_drop();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+design
design/dbgbus_pkg.sv
design/dbgbus_cmd_decode.sv
design/dbgbus_wb_master.sv
design/dbgbus_rsp_encode.sv
design/dbgbus_wb_scratch.sv
design/dbgbus_top.sv
testbench/dbgbus_props.sv
testbench/dbgbus_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module dbgbus_tb -f files.f
	./obj_dir/Vdbgbus_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
